/* common/mac_tx_pkg.sv */
`default_nettype none

package mac_tx_pkg;

    ////////////////////
    // framing
    ////////////////////
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hd5;

    localparam int PREAMBLE_LEN = 8;      // 7 x 0x55 plus sfd
    localparam int MIN_PAYLOAD  = 60;
    localparam int MAX_PAYLOAD  = 1514;
    localparam int CRC_BYTES    = 4;
    localparam int IFG_CYCLES   = 12;     // idle line cycles after a frame

    ////////////////////
    // crc-32
    ////////////////////
    // reflected form, lsb of each byte first
    localparam logic [31:0] CRC_INIT = 32'hffff_ffff;
    localparam logic [31:0] CRC_POLY = 32'hedb8_8320;

    ////////////////////
    // descriptors
    ////////////////////
    typedef logic [10:0] len_t;
    typedef logic [15:0] ptr_word_t;      // length in [10:0], upper bits unused

    typedef struct packed {
        logic gmii;                       // speed[1] when the frame was built
        len_t wire_len;                   // padded payload plus 12
    } tx_desc_t;

endpackage

`default_nettype wire

/* hw/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic                   tx_master_clk,
    input  logic                   rstn,
    input  logic                   wr,
    input  payload_t               wdata,
    input  logic                   rd,
    output payload_t               rdata,
    output logic                   empty,
    output logic                   full,
    output logic [$clog2(DEPTH):0] free
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH) + 1;

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] count_next;

    // circular pointer, depth need not be a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge tx_master_clk) begin
        if (wr)
            mem[wr_ptr] <= wdata;
        if (rd)
            rdata <= mem[rd_ptr];     // shows up one cycle after the strobe
    end

    always_comb begin
        count_next = count;
        if (wr && !rd)
            count_next = count + 1'b1;
        else if (rd && !wr)
            count_next = count - 1'b1;
    end

    always_ff @(posedge tx_master_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
            free   <= CW'(DEPTH);
        end else begin
            if (wr)
                wr_ptr <= ptr_inc(wr_ptr);
            if (rd)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count_next;
            empty <= (count_next == '0);
            full  <= (count_next == CW'(DEPTH));
            free  <= CW'(DEPTH) - count_next;
        end
    end

    a_no_overflow: assert property (@(posedge tx_master_clk) disable iff (!rstn)
        wr |-> !full);
    a_no_underflow: assert property (@(posedge tx_master_clk) disable iff (!rstn)
        rd |-> !empty);

endmodule

`default_nettype wire

/* hw/crc32_8023.sv */
`default_nettype none

module crc32_8023 (
    input  logic       tx_master_clk,
    input  logic       rstn,
    input  logic       init,
    input  logic       calc,
    input  logic [7:0] d,
    input  logic       shift,
    output logic [7:0] crc_byte
);

    logic [31:0] crc;

    // one byte through the reflected lfsr, bit 0 first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ b[i])
                r = (r >> 1) ^ mac_tx_pkg::CRC_POLY;
            else
                r = r >> 1;
        end
        return r;
    endfunction

    always_ff @(posedge tx_master_clk or negedge rstn) begin
        if (!rstn) begin
            crc <= mac_tx_pkg::CRC_INIT;
        end else begin
            if (init)
                crc <= mac_tx_pkg::CRC_INIT;
            else if (calc)
                crc <= crc_step(crc, d);
            else if (shift)
                crc <= {8'h00, crc[31:8]};    // next result byte into place
        end
    end

    // fcs goes out inverted, low byte first
    assign crc_byte = ~crc[7:0];

endmodule

`default_nettype wire

/* mac_tx_framer/mac_tx_framer.sv */
`default_nettype none

module mac_tx_framer #(
    parameter int DATA_FIFO_DEPTH = 2048
) (
    input  logic                             tx_master_clk,
    input  logic                             rstn,
    input  logic [1:0]                       speed,
    input  logic                             ptr_fifo_empty,
    input  mac_tx_pkg::ptr_word_t            ptr_fifo_din,
    output logic                             ptr_fifo_rd,
    input  logic [7:0]                       data_fifo_din,
    output logic                             data_fifo_rd,
    input  logic                             tptr_fifo_empty,
    input  mac_tx_pkg::ptr_word_t            tptr_fifo_din,
    output logic                             tptr_fifo_rd,
    input  logic [7:0]                       tdata_fifo_din,
    output logic                             tdata_fifo_rd,
    output logic                             byte_wr,
    output logic [7:0]                       byte_wdata,
    input  logic [$clog2(DATA_FIFO_DEPTH):0] byte_free,
    output logic                             desc_wr,
    output mac_tx_pkg::tx_desc_t             desc_wdata,
    input  logic                             desc_full
);

    localparam int FREE_W    = $clog2(DATA_FIFO_DEPTH) + 1;
    localparam int FRAME_MAX = mac_tx_pkg::PREAMBLE_LEN + mac_tx_pkg::MAX_PAYLOAD
                             + mac_tx_pkg::CRC_BYTES;

    localparam mac_tx_pkg::len_t PREA_LAST = mac_tx_pkg::len_t'(mac_tx_pkg::PREAMBLE_LEN - 1);
    localparam mac_tx_pkg::len_t CRC_LAST  = mac_tx_pkg::len_t'(mac_tx_pkg::CRC_BYTES - 1);
    localparam mac_tx_pkg::len_t MIN_LEN   = mac_tx_pkg::len_t'(mac_tx_pkg::MIN_PAYLOAD);
    localparam mac_tx_pkg::len_t OVERHEAD  =
        mac_tx_pkg::len_t'(mac_tx_pkg::PREAMBLE_LEN + mac_tx_pkg::CRC_BYTES);

    typedef enum logic [5:0] {
        S_IDLE = 6'b000001,
        S_PTR  = 6'b000010,       // pointer pulse to the chosen queue
        S_PREA = 6'b000100,
        S_DATA = 6'b001000,
        S_CRC  = 6'b010000,
        S_DESC = 6'b100000
    } state_t;

    state_t           state;
    state_t           state_next;
    logic             dir;        // 1 = tte queue
    logic             start;
    logic             src_rd;
    mac_tx_pkg::len_t cnt;        // byte index inside the current state
    mac_tx_pkg::len_t len;
    mac_tx_pkg::len_t pad_len;
    mac_tx_pkg::len_t ptr_len;
    logic [7:0]       src_data;
    logic [7:0]       pay_byte;
    logic [7:0]       crc_byte;

    // room for a maximum frame and a descriptor slot
    assign start = (!ptr_fifo_empty || !tptr_fifo_empty)
                && (byte_free >= FREE_W'(FRAME_MAX))
                && !desc_full;

    assign ptr_len  = dir ? tptr_fifo_din[10:0] : ptr_fifo_din[10:0];
    assign src_data = dir ? tdata_fifo_din : data_fifo_din;
    assign pay_byte = (cnt < len) ? src_data : 8'h00;     // zero pad past len

    always_comb begin
        case (state)
            S_IDLE:  state_next = start ? S_PTR : S_IDLE;
            S_PTR:   state_next = S_PREA;
            S_PREA:  state_next = (cnt == PREA_LAST) ? S_DATA : S_PREA;
            S_DATA:  state_next = (cnt == pad_len - 1'b1) ? S_CRC : S_DATA;
            S_CRC:   state_next = (cnt == CRC_LAST) ? S_DESC : S_CRC;
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge tx_master_clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
            cnt   <= '0;
            dir   <= 1'b0;
        end else begin
            state <= state_next;
            if (state_next != state || state == S_IDLE)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
            if (state == S_IDLE && start)
                dir <= !tptr_fifo_empty;              // tte wins
        end
    end

    // descriptor arrives on the first preamble cycle
    always_ff @(posedge tx_master_clk) begin
        if (state == S_PREA && cnt == '0) begin
            len     <= ptr_len;
            pad_len <= (ptr_len < MIN_LEN) ? MIN_LEN : ptr_len;
        end
    end

    ////////////////////
    // source strobes
    ////////////////////
    assign ptr_fifo_rd  = (state == S_PTR) && !dir;
    assign tptr_fifo_rd = (state == S_PTR) && dir;

    // one cycle ahead of the byte that uses it
    assign src_rd = (state == S_PREA && cnt == PREA_LAST && len != '0)
                 || (state == S_DATA && (cnt + 1'b1) < len);
    assign data_fifo_rd  = src_rd && !dir;
    assign tdata_fifo_rd = src_rd && dir;

    ////////////////////
    // fifo writes
    ////////////////////
    assign byte_wr = (state == S_PREA) || (state == S_DATA) || (state == S_CRC);

    always_comb begin
        case (state)
            S_PREA:  byte_wdata = (cnt == PREA_LAST) ? mac_tx_pkg::SFD_BYTE
                                                     : mac_tx_pkg::PREAMBLE_BYTE;
            S_DATA:  byte_wdata = pay_byte;
            S_CRC:   byte_wdata = crc_byte;
            default: byte_wdata = 8'h00;
        endcase
    end

    assign desc_wr = (state == S_DESC);

    always_comb begin
        desc_wdata.gmii     = speed[1];
        desc_wdata.wire_len = pad_len + OVERHEAD;
    end

    crc32_8023 u_crc (
        .tx_master_clk (tx_master_clk),
        .rstn          (rstn),
        .init          (state == S_PTR),
        .calc          (state == S_DATA),
        .d             (pay_byte),
        .shift         (state == S_CRC),
        .crc_byte      (crc_byte)
    );

    a_no_write_full: assert property (@(posedge tx_master_clk) disable iff (!rstn)
        byte_wr |-> byte_free != '0);

endmodule

`default_nettype wire

/* mac_tx_line/mac_tx_line.sv */
`default_nettype none

module mac_tx_line (
    input  logic                 tx_master_clk,
    input  logic                 rstn,
    input  logic                 desc_empty,
    output logic                 desc_rd,
    input  mac_tx_pkg::tx_desc_t desc_rdata,
    output logic                 byte_rd,
    input  logic [7:0]           byte_rdata,
    output logic                 gtx_dv,
    output logic [7:0]           gtx_d
);

    localparam mac_tx_pkg::len_t GAP_LAST = mac_tx_pkg::len_t'(mac_tx_pkg::IFG_CYCLES - 1);

    typedef enum logic [4:0] {
        S_IDLE = 5'b00001,
        S_RD   = 5'b00010,        // pop descriptor and first byte
        S_WAIT = 5'b00100,        // both visible now
        S_DATA = 5'b01000,
        S_GAP  = 5'b10000
    } state_t;

    state_t           state;
    state_t           state_next;
    logic             gmii;
    logic             phase;      // high nibble due next, mii only
    mac_tx_pkg::len_t cnt;        // bytes left, then gap cycles

    logic             produce;
    logic             cur_gmii;
    logic             hi;
    logic             finish;     // current byte fully on the line
    mac_tx_pkg::len_t rem;
    logic [7:0]       line_word;

    ////////////////////
    // word former
    ////////////////////
    // wait state takes mode and length straight off the fifo
    assign produce  = (state == S_WAIT) || (state == S_DATA);
    assign cur_gmii = (state == S_WAIT) ? desc_rdata.gmii : gmii;
    assign rem      = (state == S_WAIT) ? desc_rdata.wire_len : cnt;
    assign hi       = (state == S_DATA) && phase;
    assign finish   = cur_gmii || hi;

    always_comb begin
        if (cur_gmii)
            line_word = byte_rdata;
        else if (hi)
            line_word = {4'h0, byte_rdata[7:4]};
        else
            line_word = {4'h0, byte_rdata[3:0]};        // low nibble first
    end

    assign desc_rd = (state == S_RD);
    assign byte_rd = (state == S_RD) || (produce && finish && rem > 11'd1);

    always_comb begin
        case (state)
            S_IDLE:  state_next = desc_empty ? S_IDLE : S_RD;
            S_RD:    state_next = S_WAIT;
            S_WAIT:  state_next = S_DATA;
            S_DATA:  state_next = (finish && rem == 11'd1) ? S_GAP : S_DATA;
            S_GAP:   state_next = (cnt == '0) ? S_IDLE : S_GAP;
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge tx_master_clk or negedge rstn) begin
        if (!rstn) begin
            state  <= S_IDLE;
            gmii   <= 1'b0;
            phase  <= 1'b0;
            cnt    <= '0;
            gtx_dv <= 1'b0;
            gtx_d  <= 8'h00;
        end else begin
            state <= state_next;
            if (state == S_WAIT)
                gmii <= desc_rdata.gmii;
            if (produce)
                phase <= !finish;
            if (state == S_DATA && state_next == S_GAP)
                cnt <= GAP_LAST;
            else if (produce)
                cnt <= finish ? rem - 1'b1 : rem;
            else if (state == S_GAP)
                cnt <= cnt - 1'b1;
            gtx_dv <= produce;
            gtx_d  <= produce ? line_word : 8'h00;
        end
    end

    // once a frame ends the line stays quiet for the whole gap
    a_no_dv_in_gap: assert property (@(posedge tx_master_clk) disable iff (!rstn)
        $fell(gtx_dv) |-> (!gtx_dv) [*mac_tx_pkg::IFG_CYCLES]);

endmodule

`default_nettype wire

/* hw/mac_tx_top.sv */
`default_nettype none

module mac_tx_top #(
    parameter int DATA_FIFO_DEPTH = 2048,
    parameter int DESC_FIFO_DEPTH = 4
) (
    input  logic                  tx_master_clk,
    input  logic                  rstn,
    input  logic [1:0]            speed,
    // normal queue
    input  logic                  ptr_fifo_empty,
    input  mac_tx_pkg::ptr_word_t ptr_fifo_din,
    output logic                  ptr_fifo_rd,
    input  logic [7:0]            data_fifo_din,
    output logic                  data_fifo_rd,
    // tte queue
    input  logic                  tptr_fifo_empty,
    input  mac_tx_pkg::ptr_word_t tptr_fifo_din,
    output logic                  tptr_fifo_rd,
    input  logic [7:0]            tdata_fifo_din,
    output logic                  tdata_fifo_rd,
    // line
    output logic                  gtx_dv,
    output logic [7:0]            gtx_d
);

    logic                                byte_wr;
    logic [7:0]                          byte_wdata;
    logic                                byte_rd;
    logic [7:0]                          byte_rdata;
    logic [$clog2(DATA_FIFO_DEPTH):0]    byte_free;
    logic                                desc_wr;
    mac_tx_pkg::tx_desc_t                desc_wdata;
    logic                                desc_rd;
    mac_tx_pkg::tx_desc_t                desc_rdata;
    logic                                desc_empty;
    logic                                desc_full;

    mac_tx_framer #(
        .DATA_FIFO_DEPTH (DATA_FIFO_DEPTH)
    ) u_framer (
        .tx_master_clk   (tx_master_clk),
        .rstn            (rstn),
        .speed           (speed),
        .ptr_fifo_empty  (ptr_fifo_empty),
        .ptr_fifo_din    (ptr_fifo_din),
        .ptr_fifo_rd     (ptr_fifo_rd),
        .data_fifo_din   (data_fifo_din),
        .data_fifo_rd    (data_fifo_rd),
        .tptr_fifo_empty (tptr_fifo_empty),
        .tptr_fifo_din   (tptr_fifo_din),
        .tptr_fifo_rd    (tptr_fifo_rd),
        .tdata_fifo_din  (tdata_fifo_din),
        .tdata_fifo_rd   (tdata_fifo_rd),
        .byte_wr         (byte_wr),
        .byte_wdata      (byte_wdata),
        .byte_free       (byte_free),
        .desc_wr         (desc_wr),
        .desc_wdata      (desc_wdata),
        .desc_full       (desc_full)
    );

    // whole built frames, preamble through fcs
    sync_fifo #(
        .payload_t (logic [7:0]),
        .DEPTH     (DATA_FIFO_DEPTH)
    ) u_data_fifo (
        .tx_master_clk (tx_master_clk),
        .rstn          (rstn),
        .wr            (byte_wr),
        .wdata         (byte_wdata),
        .rd            (byte_rd),
        .rdata         (byte_rdata),
        .empty         (),
        .full          (),
        .free          (byte_free)
    );

    sync_fifo #(
        .payload_t (mac_tx_pkg::tx_desc_t),
        .DEPTH     (DESC_FIFO_DEPTH)
    ) u_desc_fifo (
        .tx_master_clk (tx_master_clk),
        .rstn          (rstn),
        .wr            (desc_wr),
        .wdata         (desc_wdata),
        .rd            (desc_rd),
        .rdata         (desc_rdata),
        .empty         (desc_empty),
        .full          (desc_full),
        .free          ()
    );

    mac_tx_line u_line (
        .tx_master_clk (tx_master_clk),
        .rstn          (rstn),
        .desc_empty    (desc_empty),
        .desc_rd       (desc_rd),
        .desc_rdata    (desc_rdata),
        .byte_rd       (byte_rd),
        .byte_rdata    (byte_rdata),
        .gtx_dv        (gtx_dv),
        .gtx_d         (gtx_d)
    );

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
    parameter int RESET_CYCLES = 4
) (
    output logic tx_master_clk,
    output logic rstn
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        tx_master_clk = 1'b0;
        forever #2 tx_master_clk = ~tx_master_clk;    // 4 ns period
    end

    // release on a falling edge, away from the dut's sampling edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge tx_master_clk);
        @(negedge tx_master_clk);
        rstn = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tb_mac_tx.sv */
`default_nettype none

module tb_mac_tx;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int Q_NORMAL = 0;
    localparam int Q_TTE    = 1;
    localparam int Q_BOTH   = 2;      // one frame per queue, tte expected first
    localparam int N_TESTS  = 6;
    localparam int IFG      = mac_tx_pkg::IFG_CYCLES;

    logic        tx_master_clk;
    logic        rstn;
    logic [1:0]  speed;
    logic        ptr_fifo_empty;
    logic [15:0] ptr_fifo_din;
    logic        ptr_fifo_rd;
    logic [7:0]  data_fifo_din;
    logic        data_fifo_rd;
    logic        tptr_fifo_empty;
    logic [15:0] tptr_fifo_din;
    logic        tptr_fifo_rd;
    logic [7:0]  tdata_fifo_din;
    logic        tdata_fifo_rd;
    logic        gtx_dv;
    logic [7:0]  gtx_d;

    ////////////////////
    // stimulus table
    ////////////////////
    string      t_name  [N_TESTS] = '{"gmii_100", "short_20", "mii_64", "tte_gmii",
                                      "tte_first", "backpressure"};
    int         t_queue [N_TESTS] = '{Q_NORMAL, Q_NORMAL, Q_NORMAL, Q_TTE, Q_BOTH, Q_NORMAL};
    int         t_len   [N_TESTS] = '{100, 20, 64, 200, 80, 1514};
    logic [1:0] t_speed [N_TESTS] = '{2'b10, 2'b10, 2'b00, 2'b10, 2'b11, 2'b00};
    int         t_count [N_TESTS] = '{1, 1, 1, 2, 1, 6};

    logic [15:0] n_ptr_words [$];
    logic [15:0] t_ptr_words [$];
    logic [7:0]  n_data_q [$];
    logic [7:0]  t_data_q [$];
    logic        n_ptr_pend, t_ptr_pend, n_data_pend, t_data_pend;

    logic [7:0]  exp_bytes [$];       // every expected frame back to back
    int          exp_lens [$];        // wire length of each expected frame
    logic [7:0]  got [$];
    logic [31:0] crc_tab [256];

    string       cur_name;
    logic        cur_gmii;
    int          err_count;
    int          frames_done;
    int          cycles;
    int          limit;
    logic        in_frame, seen_frame, hi_nib;
    logic [3:0]  lo_nib;
    int          dv_cycles;
    int          idle_cnt;

    tb_clk_gen u_clk_gen (
        .tx_master_clk (tx_master_clk),
        .rstn          (rstn)
    );

    mac_tx_top dut (.*);

    task automatic report_mismatch(input string what, input int expv, input int actv);
        $display("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h", cur_name, what, expv, actv);
        err_count++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %s: %s", cur_name, msg);
        err_count++;
    endtask

    // byte-at-a-time table for the reflected 802.3 polynomial
    task automatic build_crc_table();
        logic [31:0] c;
        for (int i = 0; i < 256; i++) begin
            c = 32'(i);
            for (int k = 0; k < 8; k++)
                c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
            crc_tab[i] = c;
        end
    endtask

    // payload into a source queue, whole wire frame into the expected list
    task automatic queue_frame(input int q, input int len);
        logic [7:0]  b;
        logic [31:0] crc;
        int          padded;
        padded = (len < mac_tx_pkg::MIN_PAYLOAD) ? mac_tx_pkg::MIN_PAYLOAD : len;
        crc = 32'hffff_ffff;
        repeat (7) exp_bytes.push_back(8'h55);
        exp_bytes.push_back(8'hd5);
        for (int i = 0; i < padded; i++) begin
            b = (i < len) ? 8'($urandom) : 8'h00;
            if (i < len && q == Q_TTE)
                t_data_q.push_back(b);
            else if (i < len)
                n_data_q.push_back(b);
            exp_bytes.push_back(b);
            crc = crc_tab[crc[7:0] ^ b] ^ (crc >> 8);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++)
            exp_bytes.push_back(crc[8*i +: 8]);     // lowest byte first
        exp_lens.push_back(padded + 12);
        if (q == Q_TTE)
            t_ptr_words.push_back({5'($urandom), 11'(len)});    // junk in the upper bits
        else
            n_ptr_words.push_back({5'($urandom), 11'(len)});
    endtask

    task automatic check_frame();
        int         n;
        int         bad;
        logic [7:0] e;
        if (exp_lens.size() == 0) begin
            report_error("a frame came out with no frame queued");
        end else begin
            n = exp_lens.pop_front();
            if (dv_cycles != n * (cur_gmii ? 1 : 2))
                report_mismatch("dv cycles", n * (cur_gmii ? 1 : 2), dv_cycles);
            bad = 0;
            for (int i = 0; i < n; i++) begin
                e = exp_bytes.pop_front();
                if (bad == 0 && i < got.size() && got[i] !== e) begin
                    report_mismatch($sformatf("frame %0d byte %0d", frames_done, i), e, got[i]);
                    bad = 1;                         // first bad byte only
                end
            end
        end
        frames_done++;
    endtask

    task automatic check_idle_outputs(input string when);
        if (gtx_dv !== 1'b0 || gtx_d !== 8'h00)
            report_mismatch({when, " gtx_dv,gtx_d"}, 0, {gtx_dv, gtx_d});
        if ({ptr_fifo_rd, tptr_fifo_rd, data_fifo_rd, tdata_fifo_rd,
             dut.byte_wr, dut.desc_wr, dut.byte_rd, dut.desc_rd} !== 8'h00)
            report_mismatch({when, " read/write strobes"}, 0,
                            {ptr_fifo_rd, tptr_fifo_rd, data_fifo_rd, tdata_fifo_rd,
                             dut.byte_wr, dut.desc_wr, dut.byte_rd, dut.desc_rd});
    endtask

    function automatic int cycle_limit();
        int total;
        int frame_bytes;
        int mult;
        int frames;
        total = 20;
        for (int t = 0; t < N_TESTS; t++) begin
            frame_bytes = mac_tx_pkg::PREAMBLE_LEN + mac_tx_pkg::CRC_BYTES
                        + ((t_len[t] < 60) ? 60 : t_len[t]);
            mult        = t_speed[t][1] ? 1 : 2;
            frames      = t_count[t] * ((t_queue[t] == Q_BOTH) ? 2 : 1);
            total += frames * (frame_bytes * (mult + 1) + IFG + 50) + 50;  // build, then play out
        end
        return total;
    endfunction

    ////////////////////
    // source queue models
    ////////////////////
    // data shows up one cycle after the strobe
    always @(negedge tx_master_clk) begin
        if (n_ptr_pend && n_ptr_words.size() == 0)
            report_error("normal descriptor read while empty");
        else if (n_ptr_pend)
            ptr_fifo_din = n_ptr_words.pop_front();
        if (t_ptr_pend && t_ptr_words.size() == 0)
            report_error("tte descriptor read while empty");
        else if (t_ptr_pend)
            tptr_fifo_din = t_ptr_words.pop_front();
        if (n_data_pend && n_data_q.size() == 0)
            report_error("normal byte read past the queued data");
        else if (n_data_pend)
            data_fifo_din = n_data_q.pop_front();
        if (t_data_pend && t_data_q.size() == 0)
            report_error("tte byte read past the queued data");
        else if (t_data_pend)
            tdata_fifo_din = t_data_q.pop_front();
        n_ptr_pend      = ptr_fifo_rd;
        t_ptr_pend      = tptr_fifo_rd;
        n_data_pend     = data_fifo_rd;
        t_data_pend     = tdata_fifo_rd;
        ptr_fifo_empty  = (n_ptr_words.size() == 0);
        tptr_fifo_empty = (t_ptr_words.size() == 0);
    end

    ////////////////////
    // line monitor
    ////////////////////
    always @(negedge tx_master_clk) begin
        if (rstn) begin
            if (gtx_dv) begin
                if (!in_frame) begin
                    if (seen_frame && idle_cnt < IFG)
                        report_error($sformatf("only %0d idle cycles before a frame", idle_cnt));
                    in_frame  = 1'b1;
                    dv_cycles = 0;
                    hi_nib    = 1'b0;
                    got.delete();
                end
                dv_cycles++;
                if (cur_gmii) begin
                    got.push_back(gtx_d);
                end else begin
                    if (gtx_d[7:4] != 4'h0)
                        report_mismatch("gtx_d[7:4]", 0, gtx_d[7:4]);
                    if (hi_nib)
                        got.push_back({gtx_d[3:0], lo_nib});     // low nibble came first
                    lo_nib = gtx_d[3:0];
                    hi_nib = !hi_nib;
                end
            end else begin
                if (in_frame) begin
                    in_frame   = 1'b0;
                    seen_frame = 1'b1;
                    idle_cnt   = 0;
                    check_frame();
                end
                idle_cnt++;
            end
        end
    end

    always @(posedge tx_master_clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, %0d frames still expected",
                     cycles, exp_lens.size());
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int errs_before;
        int target;
        int failed_tests;
        speed           = 2'b00;
        ptr_fifo_empty  = 1'b1;
        ptr_fifo_din    = '0;
        data_fifo_din   = '0;
        tptr_fifo_empty = 1'b1;
        tptr_fifo_din   = '0;
        tdata_fifo_din  = '0;
        {n_ptr_pend, t_ptr_pend, n_data_pend, t_data_pend} = '0;
        {in_frame, seen_frame, hi_nib} = '0;
        lo_nib       = '0;
        dv_cycles    = 0;
        idle_cnt     = 0;
        err_count    = 0;
        frames_done  = 0;
        cycles       = 0;
        failed_tests = 0;
        cur_name     = "reset";
        cur_gmii     = 1'b1;
        void'($urandom(98176));
        build_crc_table();
        limit = cycle_limit();

        repeat (2) @(negedge tx_master_clk);
        check_idle_outputs("in reset");
        wait (rstn);
        repeat (3) @(negedge tx_master_clk);
        check_idle_outputs("after reset");
        $display("%-14s %s", "reset", (err_count == 0) ? "passed" : "FAILED");

        for (int t = 0; t < N_TESTS; t++) begin
            @(negedge tx_master_clk);
            errs_before = err_count;
            cur_name    = t_name[t];
            cur_gmii    = t_speed[t][1];
            speed       = t_speed[t];
            target      = frames_done + t_count[t] * ((t_queue[t] == Q_BOTH) ? 2 : 1);
            @(posedge tx_master_clk);
            for (int k = 0; k < t_count[t]; k++) begin
                if (t_queue[t] == Q_BOTH) begin
                    queue_frame(Q_TTE, t_len[t]);
                    queue_frame(Q_NORMAL, t_len[t]);
                end else begin
                    queue_frame(t_queue[t], t_len[t]);
                end
            end
            while (frames_done < target)
                @(negedge tx_master_clk);
            repeat (20) @(negedge tx_master_clk);      // room for a stray extra frame
            if (in_frame)
                report_error("a frame beyond the queued ones is on the line");
            if (err_count != errs_before)
                failed_tests++;
            $display("%-14s %s  frames %0d  errors %0d", cur_name,
                     (err_count == errs_before) ? "passed" : "FAILED",
                     target, err_count - errs_before);
        end

        $display("summary: %0d tests, %0d failed, %0d errors, %0d frames checked",
                 N_TESTS, failed_tests, err_count, frames_done);
        if (err_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* mac_tx_top.f */
common/mac_tx_pkg.sv
hw/sync_fifo.sv
hw/crc32_8023.sv
mac_tx_framer/mac_tx_framer.sv
mac_tx_line/mac_tx_line.sv
hw/mac_tx_top.sv
tb/tb_clk_gen.sv
tb/tb_mac_tx.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_mac_tx -f mac_tx_top.f -o sim_mac_tx > build.log 2>&1 \
    || { cat build.log; echo "verilator build error"; exit 1; }

./obj_dir/sim_mac_tx > sim.log 2>&1
cat sim.log

grep -q "Something failed" sim.log && { echo "simulation result: FAIL"; exit 1; }
grep -q "Everything OK" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation result: PASS"
